/* bench/cache_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_assert (
  input wire                       clk,
  input wire                       rst_n,
  input wire                       busy,
  input wire cache_pkg::sdrc_cmd_t sdrc_cmd
);
  import cache_pkg::*;

  // every controller command is a single cycle pulse
  cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    sdrc_cmd.cmd_en |=> !sdrc_cmd.cmd_en)
    else $error("cmd_en high for two cycles in a row");

  // apart from the start-up refresh the controller only works for a waiting requester
  cmd_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (sdrc_cmd.cmd_en && (sdrc_cmd.cmd != cmd_refresh)) |-> busy)
    else $error("controller command issued while the requester was not waiting");

  // a burst opens its row with an activate, then one gap cycle
  burst_after_act: assert property (@(posedge clk) disable iff (!rst_n)
    (sdrc_cmd.cmd_en && (sdrc_cmd.cmd == cmd_read || sdrc_cmd.cmd == cmd_write)) |->
      ($past(sdrc_cmd.cmd_en, 2) && ($past(sdrc_cmd.cmd, 2) == cmd_activate)))
    else $error("read or write burst without an activate two cycles before");

endmodule

bind cache_top cache_assert u_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .busy     (busy),
  .sdrc_cmd (sdrc_cmd)
);

`default_nettype wire

/* bench/cache_stim.txt */
# op (0 read, 1 write), byte addr, wdata, wstrb, expected read data, all hex
# the expected column is ignored for writes
0 00000024 00000000 0 a5000009
0 0000003c 00000000 0 a500000f
1 00000028 11223344 5 00000000
0 00000028 00000000 0 a5220044
1 0000002c deadbeef f 00000000
0 00000220 00000000 0 a5000088
0 0000002c 00000000 0 deadbeef
0 00000028 00000000 0 a5220044
1 00000444 cafef00d c 00000000
0 00000444 00000000 0 cafe0111
0 00000040 00000000 0 a5000010
0 00000444 00000000 0 cafe0111
1 000001e0 01020304 3 00000000
0 000001fc 00000000 0 a500007f
0 001fffe0 00000000 0 a507fff8
0 000001e0 00000000 0 a5000304
0 000001e4 00000000 0 a5000079

/* bench/sdram_ctrl_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_model (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire  cache_pkg::sdrc_cmd_t         cmd,
  output cache_pkg::sdrc_rsp_t               rsp,
  output logic [cache_pkg::RAM_ADDR_W-1:0]   wb_addr,
  output logic [255:0]                       wb_line,
  output logic [31:0]                        wb_count
);
  import cache_pkg::*;

  // only written words are stored, the rest follow the start-up pattern
  logic [31:0] mem [int];
  int ack_timer;
  int rd_timer;
  int rd_base;
  int wr_idx;
  int wr_base;

  function automatic logic [31:0] load_word(input int k);
    if (mem.exists(k)) begin
      return mem[k];
    end
    return 32'ha500_0000 + 32'(k);
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp <= '0;
      wb_addr <= '0;
      wb_line <= '0;
      wb_count <= '0;
      ack_timer <= 0;
      rd_timer <= 0;
      rd_base <= 0;
      wr_idx <= 0;
      wr_base <= 0;
    end else begin
      rsp.cmd_ack <= 1'b0;
      if (ack_timer == 1) begin
        rsp.cmd_ack <= 1'b1;
        rsp.init_done <= 1'b1;
        ack_timer <= 0;
      end
      // word k is on the bus READ_WAITS+k cycles after the read command
      if (rd_timer > 0) begin
        if (rd_timer >= READ_WAITS - 1) begin
          rsp.data <= load_word(rd_base + rd_timer - (READ_WAITS - 1));
        end
        rd_timer <= (rd_timer == READ_WAITS + 6) ? 0 : rd_timer + 1;
      end
      // words 1 to 7 follow the write command cycle
      if (wr_idx > 0) begin
        mem[wr_base + wr_idx] = cmd.data;
        wb_line[32*wr_idx +: 32] <= cmd.data;
        if (wr_idx == COL_COUNT - 1) begin
          wr_idx <= 0;
          wb_count <= wb_count + 1;
        end else begin
          wr_idx <= wr_idx + 1;
        end
      end
      if (cmd.cmd_en) begin
        case (cmd.cmd)
          cmd_refresh: ack_timer <= 1;
          cmd_read: begin
            rd_timer <= 1;
            rd_base <= int'(cmd.addr >> 2);
          end
          cmd_write: begin
            mem[int'(cmd.addr >> 2)] = cmd.data;
            wb_line[31:0] <= cmd.data;
            wb_addr <= cmd.addr;
            wr_base <= int'(cmd.addr >> 2);
            wr_idx <= 1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
  import cache_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int CYCLE_LIMIT = 24 * 64 + 100;

  logic      clk;
  logic      rst_n;
  logic      enable;
  cpu_req_t  req;
  logic [31:0] data_out;
  logic      data_out_ready;
  logic      busy;
  sdrc_cmd_t sdrc_cmd;
  sdrc_rsp_t sdrc_rsp;
  logic [RAM_ADDR_W-1:0] wb_addr;
  logic [255:0] wb_line;
  logic [31:0]  wb_count;

  int mismatches = 0;
  int failures = 0;
  int cycles = 0;
  int requests = 0;
  bit ack_seen = 0;

  // expected state kept from the cache rules
  logic [31:0] shadow [int];
  logic        line_valid [16];
  logic        line_dirty [16];
  logic [11:0] line_tag [16];
  sdrc_cmd_e   seen_op [$];
  logic [RAM_ADDR_W-1:0] seen_addr [$];

  cache_top DUT (
    .clk (clk), .rst_n (rst_n), .enable (enable), .req (req),
    .data_out (data_out), .data_out_ready (data_out_ready), .busy (busy),
    .sdrc_cmd (sdrc_cmd), .sdrc_rsp (sdrc_rsp)
  );

  sdram_ctrl_model u_model (
    .clk (clk), .rst_n (rst_n), .cmd (sdrc_cmd), .rsp (sdrc_rsp),
    .wb_addr (wb_addr), .wb_line (wb_line), .wb_count (wb_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // commands are registered, so the falling edge sees each pulse once
  always @(negedge clk) begin
    if (rst_n && sdrc_cmd.cmd_en) begin
      seen_op.push_back(sdrc_cmd.cmd);
      seen_addr.push_back(sdrc_cmd.addr);
      assert (ack_seen || sdrc_cmd.cmd == cmd_refresh) else begin
        failures++;
        $display("a command other than refresh was issued before the refresh acknowledge");
      end
      // read and write bursts carry eight words
      if (sdrc_cmd.cmd == cmd_read || sdrc_cmd.cmd == cmd_write) begin
        assert (sdrc_cmd.data_len == 8'h07) else begin
          mismatches++;
          $display("mismatch sdrc_cmd.data_len: got %h expected %h",
                   sdrc_cmd.data_len, 8'h07);
        end
      end
    end
    if (rst_n && sdrc_rsp.cmd_ack) begin
      ack_seen = 1;
    end
  end

  function automatic logic [31:0] ram_word(input int k);
    if (shadow.exists(k)) begin
      return shadow[k];
    end
    return 32'ha500_0000 + 32'(k);
  endfunction

  task automatic run_request(input logic [3:0] op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             input logic [31:0] expected, input bit first);
    int line;
    int start;
    int victim_base;
    bit hit;
    bit dirty_miss;
    bit done;
    logic [11:0] tag;
    logic [31:0] merged;
    logic [31:0] wb_before;
    sdrc_cmd_e exp_op [$];
    logic [RAM_ADDR_W-1:0] exp_addr [$];
    line = int'(addr[8:5]);
    tag = addr[20:9];
    hit = line_valid[line] && line_tag[line] == tag;
    dirty_miss = !hit && line_valid[line] && line_dirty[line];
    victim_base = (int'(line_tag[line]) << 7) + (line << 3);
    if (first) begin
      exp_op.push_back(cmd_refresh);
      exp_addr.push_back('0);
    end
    if (dirty_miss) begin
      exp_op.push_back(cmd_activate);
      exp_op.push_back(cmd_write);
      exp_addr.push_back(RAM_ADDR_W'(victim_base << 2));
      exp_addr.push_back(RAM_ADDR_W'(victim_base << 2));
    end
    if (!hit) begin
      exp_op.push_back(cmd_activate);
      exp_op.push_back(cmd_read);
      exp_addr.push_back({addr[20:5], 5'b0});
      exp_addr.push_back({addr[20:5], 5'b0});
    end
    wb_before = wb_count;

    @(negedge clk);
    start = first ? 0 : seen_op.size();
    enable = 1'b1;
    req = '{addr: addr, wdata: wdata, wstrb: wstrb};
    done = 0;
    while (!done) begin
      @(negedge clk);
      done = (op == 0) ? data_out_ready : !busy;
    end

    if (op == 0) begin
      assert (data_out == expected) else begin
        mismatches++;
        $display("mismatch data_out at addr %h: got %h expected %h", addr, data_out, expected);
      end
    end
    assert (seen_op.size() - start == exp_op.size()) else begin
      mismatches++;
      $display("mismatch command count at addr %h: got %h expected %h",
               addr, seen_op.size() - start, exp_op.size());
    end
    for (int i = 0; i < exp_op.size() && start + i < seen_op.size(); i++) begin
      assert (seen_op[start+i] == exp_op[i]) else begin
        mismatches++;
        $display("mismatch sdrc_cmd.cmd: got %h expected %h", seen_op[start+i], exp_op[i]);
      end
      assert (exp_op[i] == cmd_refresh || seen_addr[start+i] == exp_addr[i]) else begin
        mismatches++;
        $display("mismatch sdrc_cmd.addr: got %h expected %h", seen_addr[start+i], exp_addr[i]);
      end
    end

    // the written-back burst must match the line as the requester left it
    if (dirty_miss) begin
      assert (wb_count == wb_before + 1) else begin
        failures++;
        $display("no complete write-back burst reached the controller");
      end
      assert (wb_addr == RAM_ADDR_W'(victim_base << 2)) else begin
        mismatches++;
        $display("mismatch wb_addr: got %h expected %h",
                 wb_addr, RAM_ADDR_W'(victim_base << 2));
      end
      for (int k = 0; k < COL_COUNT; k++) begin
        assert (wb_line[32*k +: 32] == ram_word(victim_base + k)) else begin
          mismatches++;
          $display("mismatch wb_line word %0d: got %h expected %h",
                   k, wb_line[32*k +: 32], ram_word(victim_base + k));
        end
      end
    end

    if (op != 0) begin
      merged = ram_word(int'(addr[20:2]));
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          merged[8*b +: 8] = wdata[8*b +: 8];
        end
      end
      shadow[int'(addr[20:2])] = merged;
    end
    line_dirty[line] = (op != 0) ? 1'b1 : (hit ? line_dirty[line] : 1'b0);
    line_valid[line] = 1'b1;
    line_tag[line] = tag;
    requests++;
  endtask

  initial begin
    int fd;
    int n;
    string text;
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] expected;
    rst_n = 1'b0;
    enable = 1'b0;
    req = '0;
    for (int i = 0; i < 16; i++) begin
      line_valid[i] = 1'b0;
      line_dirty[i] = 1'b0;
      line_tag[i] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("bench/cache_stim.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        text = "";
        n = $fgets(text, fd);
        if (n > 0 && text.len() > 1 && text[0] != 8'h23) begin
          n = $sscanf(text, "%h %h %h %h %h", op, addr, wdata, wstrb, expected);
          if (n == 5) begin
            run_request(op, addr, wdata, wstrb, expected, requests == 0);
          end else begin
            failures++;
            $display("malformed stimulus line: %s", text);
          end
        end
      end
      $fclose(fd);
    end
    if (requests == 0) begin
      failures++;
      $display("no request was run");
    end

    @(negedge clk);
    enable = 1'b0;
    $display("%0d requests, %0d mismatches, %0d other errors", requests, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cache/burst_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         enable,
  input  wire  cache_pkg::lookup_t    look,
  output cache_pkg::fill_t            fill,
  output cache_pkg::sdrc_cmd_t        cmd,
  input  wire  cache_pkg::sdrc_rsp_t  rsp
);
  import cache_pkg::*;

  seq_state_e state;

  // wait counter, doubles as column index during bursts
  logic [COL_IX_W-1:0] cnt;

  logic      cmd_en_q;
  sdrc_cmd_e cmd_op_q;
  logic      miss_seen;

  logic [RAM_ADDR_W-1:0] addr_q;
  logic [31:0]           data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= init_refresh;
      cnt <= '0;
      cmd_en_q <= 1'b0;
      cmd_op_q <= cmd_refresh;
      miss_seen <= 1'b0;
    end else begin
      // commands are single cycle pulses
      cmd_en_q <= 1'b0;
      // a miss must persist one cycle so dirty and victim_addr
      // come from the tag read of the current line
      miss_seen <= enable && !look.hit;

      case (state)
        init_refresh: begin
          cmd_en_q <= 1'b1;
          cmd_op_q <= cmd_refresh;
          state <= init_wait;
        end
        init_wait: begin
          if (rsp.cmd_ack) begin
            state <= idle;
          end
        end
        idle: begin
          cnt <= '0;
          if (enable && !look.hit && miss_seen) begin
            cmd_en_q <= 1'b1;
            cmd_op_q <= cmd_activate;
            state <= look.dirty ? evict_act : fill_act;
          end
        end

        evict_act: begin
          state <= evict_gap;
        end
        evict_gap: begin
          cmd_en_q <= 1'b1;
          cmd_op_q <= cmd_write;
          cnt <= cnt + 1'b1;
          state <= evict_cmd;
        end
        evict_cmd: begin
          cnt <= cnt + 1'b1;
          state <= evict_data;
        end
        evict_data: begin
          if (cnt == COL_IX_W'(COL_COUNT - 1)) begin
            cnt <= '0;
            state <= evict_wait;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        // last word is still on the bus in the first cycle here
        evict_wait: begin
          cnt <= cnt + 1'b1;
          if (cnt == COL_IX_W'(WRITE_WAITS)) begin
            cmd_en_q <= 1'b1;
            cmd_op_q <= cmd_activate;
            state <= fill_act;
          end
        end

        fill_act: begin
          state <= fill_gap;
        end
        fill_gap: begin
          cmd_en_q <= 1'b1;
          cmd_op_q <= cmd_read;
          state <= fill_cmd;
        end
        fill_cmd: begin
          cnt <= COL_IX_W'(1);
          state <= fill_wait;
        end
        fill_wait: begin
          if (cnt == COL_IX_W'(READ_WAITS - 1)) begin
            cnt <= '0;
            state <= fill_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        fill_data: begin
          cnt <= cnt + 1'b1;
          if (cnt == COL_IX_W'(COL_COUNT - 1)) begin
            state <= fill_commit;
          end
        end
        fill_commit: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // command payload
  // victim word for column cnt is loaded every cycle, so word k
  // is on the bus k cycles after the write command
  always_ff @(posedge clk) begin
    if (state == idle) begin
      addr_q <= look.dirty ? look.victim_addr : look.fill_addr;
    end else if (state == evict_wait) begin
      addr_q <= look.fill_addr;
    end
    data_q <= look.victim_word;
  end

  assign cmd = '{
    cmd_en:   cmd_en_q,
    cmd:      cmd_op_q,
    addr:     addr_q,
    data:     data_q,
    data_len: 8'(COL_COUNT - 1)
  };

  always_comb begin
    fill.busy_fill = state inside {fill_act, fill_gap, fill_cmd, fill_wait, fill_data,
                                   fill_commit};
    fill.word_we = (state == fill_data);
    fill.col = cnt;
    fill.word = rsp.data;
    fill.tag_commit = (state == fill_commit);
  end

endmodule

`default_nettype wire

/* cache/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_store (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        enable,
  input  wire  cache_pkg::cpu_req_t  req,
  input  wire  cache_pkg::fill_t     fill,
  output cache_pkg::lookup_t         look,
  output logic [31:0]                rdata,
  output logic                       data_out_ready,
  output logic                       busy
);
  import cache_pkg::*;

  // address split |tag|line|col|00|
  logic [COL_IX_W-1:0]  req_col;
  logic [LINE_IX_W-1:0] req_line;
  logic [TAG_W-1:0]     req_tag;

  assign req_col = req.addr[BYTE_OFS_W +: COL_IX_W];
  assign req_line = req.addr[BYTE_OFS_W + COL_IX_W +: LINE_IX_W];
  assign req_tag = req.addr[BYTE_OFS_W + COL_IX_W + LINE_IX_W +: TAG_W];

  logic [3:0]  tag_we;
  logic [31:0] tag_wdata;
  logic [31:0] tag_rdata;

  logic [3:0]  col_we [COL_COUNT];
  logic [31:0] col_wdata;
  logic [31:0] col_rdata [COL_COUNT];

  bram u_tag (
    .clk   (clk),
    .we    (tag_we),
    .addr  (req_line),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

  for (genvar i = 0; i < COL_COUNT; i++) begin : g_col
    bram u_col (
      .clk   (clk),
      .we    (col_we[i]),
      .addr  (req_line),
      .wdata (col_wdata),
      .rdata (col_rdata[i])
    );
  end

  // line index behind the registered tag read
  logic [LINE_IX_W-1:0] line_q;
  logic                 line_q_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_q <= '0;
      line_q_ok <= 1'b0;
    end else begin
      line_q <= req_line;
      line_q_ok <= 1'b1;
    end
  end

  logic             tag_valid;
  logic [TAG_W-1:0] cached_tag;
  logic             hit;

  assign tag_valid = tag_rdata[VALID_BIT];
  assign cached_tag = tag_rdata[TAG_W-1:0];

  // tag data only counts once it was read for the current line
  assign hit = line_q_ok && (line_q == req_line) && tag_valid && (cached_tag == req_tag);

  assign busy = enable && !hit;
  assign data_out_ready = enable && hit && (req.wstrb == '0);
  assign rdata = col_rdata[req_col];

  // line base addresses in controller byte space
  logic [RAM_ADDR_W-1:0] victim_line_addr;
  logic [RAM_ADDR_W-1:0] fill_line_addr;

  assign victim_line_addr = {cached_tag, req_line, {(COL_IX_W + BYTE_OFS_W){1'b0}}};
  assign fill_line_addr = {req_tag, req_line, {(COL_IX_W + BYTE_OFS_W){1'b0}}};

  assign look = '{
    hit:         hit,
    dirty:       tag_valid && tag_rdata[DIRTY_BIT],
    victim_addr: victim_line_addr,
    fill_addr:   fill_line_addr,
    victim_word: col_rdata[fill.col]
  };

  // column and tag writes come from the sequencer during a fill,
  // otherwise from a write hit
  always_comb begin
    for (int i = 0; i < COL_COUNT; i++) begin
      col_we[i] = '0;
    end
    tag_we = '0;
    tag_wdata = 32'({1'b0, 1'b1, req_tag});
    col_wdata = fill.busy_fill ? fill.word : req.wdata;

    if (fill.busy_fill) begin
      if (fill.word_we) begin
        col_we[fill.col] = 4'hf;
      end
      // fetched line lands clean
      if (fill.tag_commit) begin
        tag_we = 4'hf;
      end
    end else if (enable && hit && (req.wstrb != '0)) begin
      col_we[req_col] = req.wstrb;
      tag_we = 4'hf;
      tag_wdata = 32'({1'b1, 1'b1, req_tag});
    end
  end

endmodule

`default_nettype wire

/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // cache geometry
  localparam int LINE_IX_W = 4;
  localparam int COL_IX_W = 3;
  localparam int COL_COUNT = 8;
  localparam int BYTE_OFS_W = 2;

  // controller address is byte addressed
  localparam int RAM_ADDR_W = 21;
  localparam int TAG_W = RAM_ADDR_W - LINE_IX_W - COL_IX_W - BYTE_OFS_W;

  // tag word layout {dirty, valid, tag}
  localparam int VALID_BIT = TAG_W;
  localparam int DIRTY_BIT = TAG_W + 1;

  // controller timing in clock cycles
  localparam int READ_WAITS = 5;
  localparam int WRITE_WAITS = 4;

  typedef enum logic [2:0] {
    cmd_refresh  = 3'b001,
    cmd_activate = 3'b011,
    cmd_write    = 3'b100,
    cmd_read     = 3'b101
  } sdrc_cmd_e;

  typedef enum logic [3:0] {
    init_refresh,
    init_wait,
    idle,
    evict_act,
    evict_gap,
    evict_cmd,
    evict_data,
    evict_wait,
    fill_act,
    fill_gap,
    fill_cmd,
    fill_wait,
    fill_data,
    fill_commit
  } seq_state_e;

  // wstrb of zero marks a read
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic                  cmd_en;
    sdrc_cmd_e             cmd;
    logic [RAM_ADDR_W-1:0] addr;
    logic [31:0]           data;
    logic [7:0]            data_len;
  } sdrc_cmd_t;

  typedef struct packed {
    logic [31:0] data;
    logic        init_done;
    logic        cmd_ack;
  } sdrc_rsp_t;

  typedef struct packed {
    logic                  hit;
    logic                  dirty;
    logic [RAM_ADDR_W-1:0] victim_addr;
    logic [RAM_ADDR_W-1:0] fill_addr;
    logic [31:0]           victim_word;
  } lookup_t;

  typedef struct packed {
    logic                busy_fill;
    logic                word_we;
    logic [COL_IX_W-1:0] col;
    logic [31:0]         word;
    logic                tag_commit;
  } fill_t;

endpackage

`default_nettype wire

/* rtl/bram.sv */
`timescale 1ns/1ps
`default_nettype none

module bram (
  input  wire                            clk,
  input  wire  [3:0]                     we,
  input  wire  [cache_pkg::LINE_IX_W-1:0] addr,
  input  wire  [31:0]                    wdata,
  output logic [31:0]                    rdata
);
  import cache_pkg::*;

  logic [31:0] mem [2**LINE_IX_W];

  // contents start cleared, so every tag comes up invalid
  initial begin
    for (int i = 0; i < 2**LINE_IX_W; i++) begin
      mem[i] = '0;
    end
  end

  // write-first per byte lane
  // a written byte is on rdata right after the edge that stores it
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        mem[addr][8*b +: 8] <= wdata[8*b +: 8];
        rdata[8*b +: 8] <= wdata[8*b +: 8];
      end else begin
        rdata[8*b +: 8] <= mem[addr][8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         enable,
  input  wire  cache_pkg::cpu_req_t   req,
  output logic [31:0]                 data_out,
  output logic                        data_out_ready,
  output logic                        busy,
  output cache_pkg::sdrc_cmd_t        sdrc_cmd,
  input  wire  cache_pkg::sdrc_rsp_t  sdrc_rsp
);
  import cache_pkg::*;

  // store reports the looked-up line, sequencer steers fills
  lookup_t look;
  fill_t   fill_ctl;

  cache_store u_store (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .req            (req),
    .fill           (fill_ctl),
    .look           (look),
    .rdata          (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy)
  );

  burst_sequencer u_seq (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (enable),
    .look   (look),
    .fill   (fill_ctl),
    .cmd    (sdrc_cmd),
    .rsp    (sdrc_rsp)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_cache -f sim.f -o tb_cache_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" sim.log; then
  exit 0
else
  exit 1
fi

/* sim.f */
common/cache_pkg.sv
rtl/bram.sv
cache/cache_store.sv
cache/burst_sequencer.sv
rtl/cache_top.sv
bench/sdram_ctrl_model.sv
bench/cache_assert.sv
bench/tb_cache.sv
